// File: common/ctmm_defs.svh
// CTMM mLoad shared widths and encodings
// Word and register sizes, guard token permission bits,
// namespace entry layout and C-List scaling
`ifndef CTMM_DEFS_SVH
`define CTMM_DEFS_SVH

// ====================
// Widths
// ====================
// Memory word and capability word
`define CTMM_WORD_W 64
// Capability register number
`define CTMM_CR_AW 4
// C-List index
`define CTMM_INDEX_W 10

// ====================
// Guard token permissions
// ====================
// Bit positions inside the 16-bit permissions field
`define CTMM_PERM_L 0
`define CTMM_PERM_M 1
`define CTMM_PERM_G 2

// ====================
// Namespace entry layout
// ====================
// Byte offsets of limit and seals words, location sits at offset 0
`define CTMM_NS_LIMIT_OFS 8
`define CTMM_NS_SEALS_OFS 16
// Index to byte offset, one 8-byte GT per C-List slot
`define CTMM_CLIST_SHIFT 3

`endif

// File: common/ctmm_pkg.sv
// CTMM mLoad types
// Guard token and capability layouts, fault codes and the
// step encoding of the capability-fetch routine
`include "ctmm_defs.svh"

package ctmm_pkg;

    // ====================
    // Capability layout
    // ====================

    // Guard token, permissions on top, byte offset into namespace below
    typedef struct packed {
        logic [15:0] perms;
        logic [15:0] reserved;
        logic [31:0] offset;
    } gt_t;

    // Four-word capability register
    typedef struct packed {
        gt_t                      word0_gt;
        logic [`CTMM_WORD_W-1:0]  word1_location;
        logic [`CTMM_WORD_W-1:0]  word2_limit;
        logic [`CTMM_WORD_W-1:0]  word3_seals;
    } capability_reg_t;

    // Null values
    localparam gt_t             GT_NULL = '0;
    localparam capability_reg_t CR_NULL = '0;

    // ====================
    // Status and control
    // ====================

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_NULL_CAP,
        FAULT_PERM_L,
        FAULT_BOUNDS
    } fault_type_t;

    // Routine steps, in order of execution
    typedef enum logic [3:0] {
        STEP_IDLE,
        STEP_FETCH_SRC,
        STEP_CHECK_L,
        STEP_CHECK_BOUNDS,
        STEP_FETCH_W0,
        STEP_CHECK_NS,
        STEP_FETCH_W1,
        STEP_FETCH_W2,
        STEP_FETCH_W3,
        STEP_RESET_G,
        STEP_UPDATE_THREAD,
        STEP_COMPLETE,
        STEP_FAULT
    } mload_step_t;

endpackage

// File: common/mload_ctrl_if.sv
// mLoad control link between sequencer and datapath
// Sequencer publishes the current step, datapath answers
// with check verdicts, word capture and the GT G flag
`timescale 1ns/1ps

interface mload_ctrl_if;
    import ctmm_pkg::*;

    // Current routine step
    mload_step_t step;

    // Verdict of the check owned by the current step
    logic        check_ok;
    fault_type_t check_fault;

    // Memory word latched this cycle
    logic        word_taken;

    // Fetched GT carries G
    logic        gt_has_g;

    modport sequencer (
        output step,
        input  check_ok,
        input  check_fault,
        input  word_taken,
        input  gt_has_g
    );

    modport datapath (
        input  step,
        output check_ok,
        output check_fault,
        output word_taken,
        output gt_has_g
    );

endinterface

// File: mload/mload_sequencer.sv
// mLoad sequencer
// Runs the capability-fetch steps, latches the register
// numbers of the command, records the fault code and
// drives every status and write strobe from the step
`timescale 1ns/1ps
`include "ctmm_defs.svh"

module mload_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sub_start,
    input  logic [`CTMM_CR_AW-1:0]  sub_cr_src,
    input  logic [`CTMM_CR_AW-1:0]  sub_cr_dst,
    input  logic                    mem_rd_valid,
    mload_ctrl_if.sequencer         ctrl,
    output logic                    sub_busy,
    output logic                    sub_done,
    output logic                    sub_fault,
    output ctmm_pkg::fault_type_t   sub_fault_type,
    output logic [`CTMM_CR_AW-1:0]  cr_rd_addr,
    output logic [`CTMM_CR_AW-1:0]  cr_wr_addr,
    output logic                    cr_wr_en,
    output logic                    mem_rd_en,
    output logic                    thread_wr_en,
    output logic [`CTMM_CR_AW-1:0]  thread_wr_idx,
    output logic                    g_bit_reset
);
    import ctmm_pkg::*;

    mload_step_t              step_q;
    mload_step_t              step_d;
    logic [`CTMM_CR_AW-1:0]   cr_src_q;
    logic [`CTMM_CR_AW-1:0]   cr_dst_q;
    fault_type_t              fault_q;
    logic                     accept;
    logic                     word_in;

    // Commands only land while idle, busy pulses are dropped
    assign accept = (step_q == STEP_IDLE) && sub_start;

    // Word returned by memory and latched by the datapath
    assign word_in = mem_rd_valid && ctrl.word_taken;

    // ====================
    // Step register
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_q <= STEP_IDLE;
        end else begin
            step_q <= step_d;
        end
    end

    always_comb begin
        step_d = step_q;
        case (step_q)
            STEP_IDLE:          if (accept) step_d = STEP_FETCH_SRC;
            STEP_FETCH_SRC:     step_d = STEP_CHECK_L;
            // Null and permission checks share one cycle
            STEP_CHECK_L:       step_d = ctrl.check_ok ? STEP_CHECK_BOUNDS : STEP_FAULT;
            STEP_CHECK_BOUNDS:  step_d = ctrl.check_ok ? STEP_FETCH_W0 : STEP_FAULT;
            STEP_FETCH_W0:      if (word_in) step_d = STEP_CHECK_NS;
            STEP_CHECK_NS:      step_d = ctrl.check_ok ? STEP_FETCH_W1 : STEP_FAULT;
            STEP_FETCH_W1:      if (word_in) step_d = STEP_FETCH_W2;
            STEP_FETCH_W2:      if (word_in) step_d = STEP_FETCH_W3;
            STEP_FETCH_W3: begin
                // G reset only when the GT carried it
                if (word_in) begin
                    step_d = ctrl.gt_has_g ? STEP_RESET_G : STEP_UPDATE_THREAD;
                end
            end
            STEP_RESET_G:       step_d = STEP_UPDATE_THREAD;
            STEP_UPDATE_THREAD: step_d = STEP_COMPLETE;
            STEP_COMPLETE:      step_d = STEP_IDLE;
            STEP_FAULT:         step_d = STEP_IDLE;
            default:            step_d = STEP_IDLE;
        endcase
    end

    assign ctrl.step = step_q;

    // ====================
    // Operand and fault latches
    // ====================

    // Source and destination register numbers of the command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cr_src_q <= '0;
            cr_dst_q <= '0;
        end else if (accept) begin
            cr_src_q <= sub_cr_src;
            cr_dst_q <= sub_cr_dst;
        end
    end

    // Failing check leaves its code, fault cycle hands back FAULT_NONE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_q <= FAULT_NONE;
        end else if (!ctrl.check_ok) begin
            fault_q <= ctrl.check_fault;
        end else if (step_q == STEP_FAULT) begin
            fault_q <= FAULT_NONE;
        end
    end

    // ====================
    // Strobes
    // ====================

    // Status to the caller
    assign sub_busy       = (step_q != STEP_IDLE);
    assign sub_done       = (step_q == STEP_COMPLETE);
    assign sub_fault      = (step_q == STEP_FAULT);
    assign sub_fault_type = fault_q;

    // Register file read only in the fetch-source cycle
    assign cr_rd_addr = (step_q == STEP_FETCH_SRC) ? cr_src_q : '0;

    // Direct write into CRd on completion
    assign cr_wr_addr = cr_dst_q;
    assign cr_wr_en   = (step_q == STEP_COMPLETE);

    // Read request held for the whole fetch step
    assign mem_rd_en = (step_q == STEP_FETCH_W0) ||
                       (step_q == STEP_FETCH_W1) ||
                       (step_q == STEP_FETCH_W2) ||
                       (step_q == STEP_FETCH_W3);

    // Thread slot of CRd and namespace G reset
    assign thread_wr_en  = (step_q == STEP_UPDATE_THREAD);
    assign thread_wr_idx = cr_dst_q;
    assign g_bit_reset   = (step_q == STEP_RESET_G);

endmodule

// File: mload/mload_datapath.sv
// mLoad datapath
// Holds the index, the source capability and the capability
// under construction; runs the null, permission and bounds
// checks and forms memory addresses and write data
`timescale 1ns/1ps
`include "ctmm_defs.svh"

module mload_datapath (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       sub_start,
    input  logic [`CTMM_INDEX_W-1:0]   sub_index,
    input  ctmm_pkg::capability_reg_t  cr_rd_data,
    input  ctmm_pkg::capability_reg_t  cr15_namespace,
    input  logic [`CTMM_WORD_W-1:0]    mem_rd_data,
    input  logic                       mem_rd_valid,
    mload_ctrl_if.datapath             ctrl,
    output logic [`CTMM_WORD_W-1:0]    mem_addr,
    output ctmm_pkg::capability_reg_t  cr_wr_data,
    output logic [`CTMM_WORD_W-1:0]    thread_wr_data,
    output logic [`CTMM_WORD_W-1:0]    g_bit_addr
);
    import ctmm_pkg::*;

    logic [`CTMM_INDEX_W-1:0]  index_q;
    capability_reg_t           src_cap;
    capability_reg_t           result_cap;
    logic                      take_word;
    logic [`CTMM_WORD_W-1:0]   index_word;
    logic [`CTMM_WORD_W-1:0]   gt_offset_word;
    logic [`CTMM_WORD_W-1:0]   clist_addr;
    logic [`CTMM_WORD_W-1:0]   ns_entry_addr;
    logic                      src_is_null;
    logic                      src_can_load;
    logic                      index_in_bounds;
    logic                      ns_ok;
    gt_t                       gt_clear;

    // ====================
    // Operand latches
    // ====================

    // Index captured with the accepted command
    always_ff @(posedge clk) begin
        if (ctrl.step == STEP_IDLE && sub_start) begin
            index_q <= sub_index;
        end
    end

    // CRn value from the register file read cycle
    always_ff @(posedge clk) begin
        if (ctrl.step == STEP_FETCH_SRC) begin
            src_cap <= cr_rd_data;
        end
    end

    // ====================
    // Result capability
    // ====================

    // Fetch steps capture on the returning word
    assign take_word = mem_rd_valid &&
                       (ctrl.step == STEP_FETCH_W0 || ctrl.step == STEP_FETCH_W1 ||
                        ctrl.step == STEP_FETCH_W2 || ctrl.step == STEP_FETCH_W3);
    assign ctrl.word_taken = take_word;

    // Built word by word, emptied between commands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_cap <= CR_NULL;
        end else if (ctrl.step == STEP_IDLE) begin
            result_cap <= CR_NULL;
        end else if (take_word) begin
            case (ctrl.step)
                STEP_FETCH_W0: result_cap.word0_gt       <= gt_t'(mem_rd_data);
                STEP_FETCH_W1: result_cap.word1_location <= mem_rd_data;
                STEP_FETCH_W2: result_cap.word2_limit    <= mem_rd_data;
                STEP_FETCH_W3: result_cap.word3_seals    <= mem_rd_data;
                default:       result_cap <= result_cap;
            endcase
        end
    end

    assign ctrl.gt_has_g = result_cap.word0_gt.perms[`CTMM_PERM_G];

    // ====================
    // Checks
    // ====================

    assign index_word     = {{(`CTMM_WORD_W-`CTMM_INDEX_W){1'b0}}, index_q};
    assign gt_offset_word = {{(`CTMM_WORD_W-32){1'b0}}, result_cap.word0_gt.offset};

    // CRn must be live and grant L or M
    assign src_is_null  = (src_cap.word0_gt == GT_NULL);
    assign src_can_load = src_cap.word0_gt.perms[`CTMM_PERM_L] ||
                          src_cap.word0_gt.perms[`CTMM_PERM_M];

    // Index strictly below CRn limit
    assign index_in_bounds = (index_word < src_cap.word2_limit);

    // GT offset inside CR15, and CR15 needs M
    assign ns_ok = (gt_offset_word < cr15_namespace.word2_limit) &&
                   cr15_namespace.word0_gt.perms[`CTMM_PERM_M];

    // Verdict for the check owned by the current step
    always_comb begin
        ctrl.check_ok    = 1'b1;
        ctrl.check_fault = FAULT_NONE;
        case (ctrl.step)
            STEP_CHECK_L: begin
                // Null wins over missing permission
                if (src_is_null) begin
                    ctrl.check_ok    = 1'b0;
                    ctrl.check_fault = FAULT_NULL_CAP;
                end else if (!src_can_load) begin
                    ctrl.check_ok    = 1'b0;
                    ctrl.check_fault = FAULT_PERM_L;
                end
            end
            STEP_CHECK_BOUNDS: begin
                if (!index_in_bounds) begin
                    ctrl.check_ok    = 1'b0;
                    ctrl.check_fault = FAULT_BOUNDS;
                end
            end
            STEP_CHECK_NS: begin
                if (!ns_ok) begin
                    ctrl.check_ok    = 1'b0;
                    ctrl.check_fault = FAULT_BOUNDS;
                end
            end
            default: begin
                ctrl.check_ok    = 1'b1;
                ctrl.check_fault = FAULT_NONE;
            end
        endcase
    end

    // ====================
    // Addressing
    // ====================

    // GT slot in the CRn C-List
    assign clist_addr = src_cap.word1_location + (index_word << `CTMM_CLIST_SHIFT);

    // Namespace entry, GT offset is already in bytes
    assign ns_entry_addr = cr15_namespace.word1_location + gt_offset_word;

    always_comb begin
        case (ctrl.step)
            STEP_FETCH_W0: mem_addr = clist_addr;
            STEP_FETCH_W1: mem_addr = ns_entry_addr;
            STEP_FETCH_W2: mem_addr = ns_entry_addr + `CTMM_WORD_W'(`CTMM_NS_LIMIT_OFS);
            STEP_FETCH_W3: mem_addr = ns_entry_addr + `CTMM_WORD_W'(`CTMM_NS_SEALS_OFS);
            default:       mem_addr = '0;
        endcase
    end

    // G lives in the seals word of the entry
    assign g_bit_addr = ns_entry_addr + `CTMM_WORD_W'(`CTMM_NS_SEALS_OFS);

    // ====================
    // Write data
    // ====================

    // GT handed on without G
    always_comb begin
        gt_clear                    = result_cap.word0_gt;
        gt_clear.perms[`CTMM_PERM_G] = 1'b0;
    end

    always_comb begin
        cr_wr_data          = result_cap;
        cr_wr_data.word0_gt = gt_clear;
    end

    // Saved GT lets the thread reload CRd later
    assign thread_wr_data = gt_clear;

endmodule

// File: verilog/ctmm_mload.sv
// CTMM mLoad capability-fetch routine
// Trusted fetch of a capability from a C-List through the
// CR15 namespace, written straight into CRd and its thread slot
`timescale 1ns/1ps
`include "ctmm_defs.svh"

module ctmm_mload (
    input  logic                       clk,
    input  logic                       rst_n,
    // Command from the calling instruction
    input  logic                       sub_start,
    input  logic [`CTMM_CR_AW-1:0]     sub_cr_src,
    input  logic [`CTMM_CR_AW-1:0]     sub_cr_dst,
    input  logic [`CTMM_INDEX_W-1:0]   sub_index,
    output logic                       sub_busy,
    output logic                       sub_done,
    output logic                       sub_fault,
    output ctmm_pkg::fault_type_t      sub_fault_type,
    // Capability register file
    output logic [`CTMM_CR_AW-1:0]     cr_rd_addr,
    input  ctmm_pkg::capability_reg_t  cr_rd_data,
    output logic [`CTMM_CR_AW-1:0]     cr_wr_addr,
    output ctmm_pkg::capability_reg_t  cr_wr_data,
    output logic                       cr_wr_en,
    // Namespace register
    input  ctmm_pkg::capability_reg_t  cr15_namespace,
    // Memory read port
    output logic [`CTMM_WORD_W-1:0]    mem_addr,
    output logic                       mem_rd_en,
    input  logic [`CTMM_WORD_W-1:0]    mem_rd_data,
    input  logic                       mem_rd_valid,
    // Thread slot update
    output logic                       thread_wr_en,
    output logic [`CTMM_CR_AW-1:0]     thread_wr_idx,
    output logic [`CTMM_WORD_W-1:0]    thread_wr_data,
    // Namespace G reset
    output logic                       g_bit_reset,
    output logic [`CTMM_WORD_W-1:0]    g_bit_addr
);

    mload_ctrl_if ctrl_if ();

    // Steps, fault code and strobes
    mload_sequencer i_mload_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .sub_start      (sub_start),
        .sub_cr_src     (sub_cr_src),
        .sub_cr_dst     (sub_cr_dst),
        .mem_rd_valid   (mem_rd_valid),
        .ctrl           (ctrl_if.sequencer),
        .sub_busy       (sub_busy),
        .sub_done       (sub_done),
        .sub_fault      (sub_fault),
        .sub_fault_type (sub_fault_type),
        .cr_rd_addr     (cr_rd_addr),
        .cr_wr_addr     (cr_wr_addr),
        .cr_wr_en       (cr_wr_en),
        .mem_rd_en      (mem_rd_en),
        .thread_wr_en   (thread_wr_en),
        .thread_wr_idx  (thread_wr_idx),
        .g_bit_reset    (g_bit_reset)
    );

    // Latches, checks, addresses and write data
    mload_datapath i_mload_datapath (
        .clk            (clk),
        .rst_n          (rst_n),
        .sub_start      (sub_start),
        .sub_index      (sub_index),
        .cr_rd_data     (cr_rd_data),
        .cr15_namespace (cr15_namespace),
        .mem_rd_data    (mem_rd_data),
        .mem_rd_valid   (mem_rd_valid),
        .ctrl           (ctrl_if.datapath),
        .mem_addr       (mem_addr),
        .cr_wr_data     (cr_wr_data),
        .thread_wr_data (thread_wr_data),
        .g_bit_addr     (g_bit_addr)
    );

endmodule

// File: dv/tb_ctmm_mload.sv
// mLoad testbench
// Register file, CR15 and sparse memory models around the
// capability-fetch routine
// Directed cases then random commands with random memory
// latency and busy-time starts
`timescale 1ns/1ps
`include "ctmm_defs.svh"

module tb_ctmm_mload;
    import ctmm_pkg::*;

    localparam int RANDOM_CMDS = 300;
    // Worst-case command under 30 cycles leaves margin for the directed cases
    localparam int TIMEOUT_CYCLES = RANDOM_CMDS * 40;

    localparam logic [15:0] L_BIT = 16'h1 << `CTMM_PERM_L;
    localparam logic [15:0] M_BIT = 16'h1 << `CTMM_PERM_M;
    localparam logic [15:0] G_BIT = 16'h1 << `CTMM_PERM_G;

    // Expected outcome of one command
    typedef struct packed {
        fault_type_t     fault;
        logic [2:0]      n_words;
        capability_reg_t cap;
        logic [63:0]     thread_word;
        logic            g_reset;
        logic [63:0]     g_addr;
    } expect_t;

    logic                  clk;
    logic                  rst_n;
    logic                  sub_start;
    logic [3:0]            sub_cr_src;
    logic [3:0]            sub_cr_dst;
    logic [9:0]            sub_index;
    logic                  sub_busy;
    logic                  sub_done;
    logic                  sub_fault;
    fault_type_t           sub_fault_type;
    logic [3:0]            cr_rd_addr;
    capability_reg_t       cr_rd_data;
    logic [3:0]            cr_wr_addr;
    capability_reg_t       cr_wr_data;
    logic                  cr_wr_en;
    logic [63:0]           mem_addr;
    logic                  mem_rd_en;
    logic [63:0]           mem_rd_data;
    logic                  mem_rd_valid;
    logic                  thread_wr_en;
    logic [3:0]            thread_wr_idx;
    logic [63:0]           thread_wr_data;
    logic                  g_bit_reset;
    logic [63:0]           g_bit_addr;

    // Models
    capability_reg_t regs [16];
    capability_reg_t cr15;
    logic [63:0]     mem [logic [63:0]];

    // Expectation of the command in flight
    expect_t    expected;
    logic [3:0] exp_dst;

    // Cycle count and event totals each written by one process
    int cyc = 0;
    int cr_wr_total = 0;
    int thread_total = 0;
    int g_total = 0;
    int done_total = 0;
    int word_total = 0;
    int cr_wr_cyc = 0;
    int thread_cyc = 0;
    int g_cyc = 0;
    int done_cyc = 0;

    ctmm_mload i_ctmm_mload (
        .clk            (clk),
        .rst_n          (rst_n),
        .sub_start      (sub_start),
        .sub_cr_src     (sub_cr_src),
        .sub_cr_dst     (sub_cr_dst),
        .sub_index      (sub_index),
        .sub_busy       (sub_busy),
        .sub_done       (sub_done),
        .sub_fault      (sub_fault),
        .sub_fault_type (sub_fault_type),
        .cr_rd_addr     (cr_rd_addr),
        .cr_rd_data     (cr_rd_data),
        .cr_wr_addr     (cr_wr_addr),
        .cr_wr_data     (cr_wr_data),
        .cr_wr_en       (cr_wr_en),
        .cr15_namespace (cr15),
        .mem_addr       (mem_addr),
        .mem_rd_en      (mem_rd_en),
        .mem_rd_data    (mem_rd_data),
        .mem_rd_valid   (mem_rd_valid),
        .thread_wr_en   (thread_wr_en),
        .thread_wr_idx  (thread_wr_idx),
        .thread_wr_data (thread_wr_data),
        .g_bit_reset    (g_bit_reset),
        .g_bit_addr     (g_bit_addr)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Register file answers in the same cycle
    assign cr_rd_data = regs[cr_rd_addr];

    // ====================
    // Helpers
    // ====================

    task automatic check_equal(input string name, input logic [255:0] got,
                               input logic [255:0] want);
        if (got !== want) begin
            $display("FAILED %s: got %0h expected %0h", name, got, want);
            $display("*** TEST FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [63:0] mem_word(input logic [63:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        // Unwritten words follow every address bit
        return {addr[31:0] ^ 32'h9e37_79b9, addr[63:32] ^ ~addr[31:0]};
    endfunction

    function automatic gt_t make_gt(input logic [15:0] perms, input logic [31:0] offset);
        return gt_t'({perms, 16'h0000, offset});
    endfunction

    function automatic capability_reg_t make_cap(input logic [15:0] perms,
                                                 input logic [31:0] offset,
                                                 input logic [63:0] loc,
                                                 input logic [63:0] limit,
                                                 input logic [63:0] seals);
        return capability_reg_t'({make_gt(perms, offset), loc, limit, seals});
    endfunction

    // ====================
    // Reference model
    // ====================

    // Reads the register file, CR15 and memory models
    function automatic expect_t reference_mload(input logic [3:0] src, input logic [9:0] idx);
        capability_reg_t s;
        gt_t             gt;
        logic [63:0]     entry;
        expect_t         e;
        e       = '0;
        e.fault = FAULT_NONE;
        s       = regs[src];
        if (s.word0_gt == '0) begin
            e.fault = FAULT_NULL_CAP;
        end else if (!s.word0_gt.perms[`CTMM_PERM_L] && !s.word0_gt.perms[`CTMM_PERM_M]) begin
            e.fault = FAULT_PERM_L;
        end else if (64'(idx) >= s.word2_limit) begin
            e.fault = FAULT_BOUNDS;
        end else begin
            // One 8-byte GT per C-List slot
            gt        = gt_t'(mem_word(s.word1_location + (64'(idx) << 3)));
            e.n_words = 3'd1;
            if (64'(gt.offset) >= cr15.word2_limit || !cr15.word0_gt.perms[`CTMM_PERM_M]) begin
                e.fault = FAULT_BOUNDS;
            end else begin
                entry                    = cr15.word1_location + 64'(gt.offset);
                e.n_words                = 3'd4;
                e.g_reset                = gt.perms[`CTMM_PERM_G];
                e.g_addr                 = entry + 64'd16;
                gt.perms[`CTMM_PERM_G]   = 1'b0;
                e.cap = capability_reg_t'({gt, mem_word(entry), mem_word(entry + 64'd8),
                                           mem_word(entry + 64'd16)});
                e.thread_word            = 64'(gt);
            end
        end
        return e;
    endfunction

    // ====================
    // Memory, monitor, timeout
    // ====================

    // One word per request after 0 to 3 wait cycles
    initial begin
        int delay_cycles;
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_rd_valid = 1'b0;
            if (mem_rd_en) begin
                delay_cycles = $urandom % 4;
                repeat (delay_cycles) begin
                    @(posedge clk);
                    #1;
                end
                mem_rd_data  = mem_word(mem_addr);
                mem_rd_valid = 1'b1;
            end
        end
    end

    // Write events and memory words sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_rd_en && mem_rd_valid) begin
                word_total++;
            end
            if (sub_done) begin
                done_total++;
                done_cyc = cyc;
            end
            if (cr_wr_en) begin
                cr_wr_total++;
                cr_wr_cyc = cyc;
                check_equal("cr_wr_addr", 256'(cr_wr_addr), 256'(exp_dst));
                check_equal("cr_wr_data", cr_wr_data, expected.cap);
            end
            if (thread_wr_en) begin
                thread_total++;
                thread_cyc = cyc;
                check_equal("thread_wr_idx", 256'(thread_wr_idx), 256'(exp_dst));
                check_equal("thread_wr_data", 256'(thread_wr_data), 256'(expected.thread_word));
            end
            if (g_bit_reset) begin
                g_total++;
                g_cyc = cyc;
                check_equal("g_bit_addr", 256'(g_bit_addr), 256'(expected.g_addr));
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    // ====================
    // Command driver
    // ====================

    // Entered and left 1 ns after a rising edge
    task automatic run_command(input logic [3:0] src, input logic [3:0] dst,
                               input logic [9:0] idx, input bit extra);
        int          cycles;
        int          cr_base;
        int          thread_base;
        int          g_base;
        int          done_base;
        int          word_base;
        bit          finished;
        fault_type_t got_fault;
        expected    = reference_mload(src, idx);
        exp_dst     = dst;
        cr_base     = cr_wr_total;
        thread_base = thread_total;
        g_base      = g_total;
        done_base   = done_total;
        word_base   = word_total;
        cycles      = 0;
        finished    = 1'b0;
        got_fault   = FAULT_NONE;
        sub_start   = 1'b1;
        sub_cr_src  = src;
        sub_cr_dst  = dst;
        sub_index   = idx;
        while (!finished) begin
            @(posedge clk);
            #1;
            // Starts while busy must be ignored
            sub_start = extra ? 1'($urandom) : 1'b0;
            if (extra) begin
                sub_cr_src = 4'($urandom);
                sub_cr_dst = 4'($urandom);
                sub_index  = 10'($urandom);
            end
            @(negedge clk);
            cycles++;
            if (sub_fault) begin
                got_fault = sub_fault_type;
                finished  = 1'b1;
            end else if (sub_done) begin
                finished = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        sub_start = 1'b0;
        check_equal("sub_fault_type", 256'(got_fault), 256'(expected.fault));
        check_equal("sub_busy after command", 256'(sub_busy), 256'(0));
        check_equal("sub_fault_type in idle", 256'(sub_fault_type), 256'(FAULT_NONE));
        // Register checks fault at a fixed cycle
        if (expected.fault != FAULT_NONE && expected.n_words == 3'd0) begin
            check_equal("sub_fault cycle", 256'(cycles),
                        256'(expected.fault == FAULT_BOUNDS ? 4 : 3));
        end
        check_equal("memory words", 256'(word_total - word_base), 256'(expected.n_words));
        check_equal("sub_done count", 256'(done_total - done_base),
                    256'(expected.fault == FAULT_NONE));
        check_equal("cr_wr_en count", 256'(cr_wr_total - cr_base),
                    256'(expected.fault == FAULT_NONE));
        check_equal("thread_wr_en count", 256'(thread_total - thread_base),
                    256'(expected.fault == FAULT_NONE));
        check_equal("g_bit_reset count", 256'(g_total - g_base), 256'(expected.g_reset));
        if (expected.fault == FAULT_NONE) begin
            check_equal("sub_done cycle", 256'(done_cyc), 256'(thread_cyc + 1));
            check_equal("cr_wr_en cycle", 256'(cr_wr_cyc), 256'(thread_cyc + 1));
            if (expected.g_reset) begin
                check_equal("g_bit_reset cycle", 256'(g_cyc), 256'(thread_cyc - 1));
            end
        end
    endtask

    // ====================
    // Tests
    // ====================

    initial begin
        capability_reg_t s;
        logic [3:0]      src;
        logic [3:0]      dst;
        logic [9:0]      idx;
        void'($urandom(32'h0be8_2677));
        rst_n      = 1'b0;
        sub_start  = 1'b0;
        sub_cr_src = '0;
        sub_cr_dst = '0;
        sub_index  = '0;
        cr15       = CR_NULL;
        for (int r = 0; r < 16; r++) begin
            regs[r] = CR_NULL;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_equal("outputs after reset", 256'({sub_busy, sub_done, sub_fault, cr_wr_en,
                    mem_rd_en, thread_wr_en, g_bit_reset}), 256'(0));

        // C-List of 32 slots at 0x1000 and namespace at 0x8000
        regs[1] = make_cap(L_BIT, 32'h0000_0011, 64'h1000, 64'd32, 64'h0000_0000_5ea1_0001);
        cr15    = make_cap(M_BIT, 32'h0, 64'h8000, 64'h1000, 64'h0);

        // Plain load
        mem[64'h1028] = 64'(make_gt(L_BIT | M_BIT, 32'h40));
        mem[64'h8040] = 64'h0000_0000_0002_0000;
        mem[64'h8048] = 64'h0000_0000_0000_0400;
        mem[64'h8050] = 64'h0000_0000_0000_beef;
        run_command(4'd1, 4'd3, 10'd5, 1'b0);

        // GT with G and entry words from the fill pattern
        mem[64'h1030] = 64'(make_gt(M_BIT | G_BIT, 32'h80));
        run_command(4'd1, 4'd4, 10'd6, 1'b0);

        // Null and permission faults
        regs[2] = CR_NULL;
        run_command(4'd2, 4'd5, 10'd0, 1'b0);
        regs[3] = make_cap(G_BIT, 32'h20, 64'h2000, 64'd8, 64'h0);
        run_command(4'd3, 4'd6, 10'd0, 1'b0);

        // Index, GT offset and CR15 permission faults
        run_command(4'd1, 4'd7, 10'd32, 1'b0);
        mem[64'h1038] = 64'(make_gt(L_BIT, 32'h1000));
        run_command(4'd1, 4'd7, 10'd7, 1'b0);
        cr15 = make_cap(L_BIT, 32'h0, 64'h8000, 64'h1000, 64'h0);
        run_command(4'd1, 4'd8, 10'd5, 1'b0);

        // Random register file with about one entry in eight null
        for (int r = 0; r < 16; r++) begin
            if ($urandom % 8 == 0) begin
                regs[r] = CR_NULL;
            end else begin
                regs[r] = make_cap(16'($urandom % 8), $urandom, 64'(r) << 12,
                                   64'($urandom % 40), {$urandom, $urandom});
            end
        end
        for (int n = 0; n < RANDOM_CMDS; n++) begin
            src = 4'($urandom);
            dst = 4'($urandom);
            idx = 10'($urandom % 48);
            s   = regs[src];
            // Slot GT whose offset is sometimes past the CR15 limit
            mem[s.word1_location + (64'(idx) << 3)] =
                64'(make_gt(16'($urandom % 8), ($urandom % 32'h180) & ~32'h7));
            cr15 = make_cap(($urandom % 8 == 0) ? L_BIT : M_BIT, 32'h0,
                            64'h0004_0000, 64'h100, 64'h0);
            run_command(src, dst, idx, 1'($urandom));
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: tb.f
+incdir+common
common/ctmm_pkg.sv
common/mload_ctrl_if.sv
mload/mload_sequencer.sv
mload/mload_datapath.sv
verilog/ctmm_mload.sv
dv/tb_ctmm_mload.sv

// File: Makefile
# Verilator build and run of the mLoad testbench

SRCS := $(filter-out +%,$(shell cat tb.f))

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
obj_dir/Vtb_ctmm_mload: tb.f $(SRCS) $(wildcard common/*.svh)
	verilator --binary --timing --top-module tb_ctmm_mload -f tb.f -o Vtb_ctmm_mload

# Pass or fail is taken from the log
run: obj_dir/Vtb_ctmm_mload
	./obj_dir/Vtb_ctmm_mload | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
